// ==== rtl/spw_rx_pkg.sv ====
package spw_rx_pkg;

	// --------------------
	// Control codes, bits 3..2 of a control character
	localparam logic [1:0] ctrl_fct = 2'd0;
	localparam logic [1:0] ctrl_eop = 2'd1;
	localparam logic [1:0] ctrl_eep = 2'd2;
	localparam logic [1:0] ctrl_esc = 2'd3;

	// Character lengths on the line, parity and flag included
	localparam int ctrl_char_bits = 4;
	localparam int data_char_bits = 10;

	// --------------------
	// Status word, top bit down:
	// prev control, current control, parity error, got bit,
	// then the last token kind (null, nchar, time code, fct)
	// A control field is {0, flag, code}, so FCT reads 4 and ESC reads 7
	localparam int info_w         = 14;
	localparam int info_ctrl_w    = 4;
	localparam int info_prev_lsb  = 10;
	localparam int info_cur_lsb   = 6;
	localparam int info_perr_bit  = 5;
	localparam int info_got_bit   = 4;
	localparam int info_null_bit  = 3;
	localparam int info_nchar_bit = 2;
	localparam int info_time_bit  = 1;
	localparam int info_fct_bit   = 0;

	// --------------------
	// One received character, bit 0 arrived first
	typedef union packed
	{
		struct packed
		{
			logic [5:0] unused; // Zero for a control character
			logic [1:0] code;
			logic       flag;
			logic       parity;
		} ctrl;
		struct packed
		{
			logic [7:0] value;  // LSB first on the line
			logic       flag;
			logic       parity;
		} data;
	} char_word_u;

endpackage

// ==== rtl/ds_bit_sampler.sv ====
`timescale 1ns/1ps

module ds_bit_sampler #(
	parameter int SYNC_STAGES = 2
) (
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic rx_din,
	input  logic rx_sin,
	output logic bit_strobe,
	output logic bit_value,
	output logic got_bit
);

	logic [SYNC_STAGES-1:0] din_sync;
	logic [SYNC_STAGES-1:0] sin_sync;
	logic                   din_s;
	logic                   ds_xor;
	logic                   ds_xor_q;   // Edge register
	logic                   ds_edge;

	assign din_s   = din_sync[SYNC_STAGES-1];
	assign ds_xor  = din_s ^ sin_sync[SYNC_STAGES-1];
	assign ds_edge = ds_xor != ds_xor_q; // Every D/S transition is one bit

	// --------------------
	// Input synchronizers
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			din_sync <= '0;
			sin_sync <= '0;
		end
		else
		begin
			din_sync[0] <= rx_din;
			sin_sync[0] <= rx_sin;
			for (int i = 1; i < SYNC_STAGES; i++)
			begin
				din_sync[i] <= din_sync[i-1];
				sin_sync[i] <= sin_sync[i-1];
			end
		end
	end

	// --------------------
	// Edge detect and bit strobe
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			ds_xor_q   <= 1'b0;
			bit_strobe <= 1'b0;
			got_bit    <= 1'b0;
		end
		else
		begin
			ds_xor_q   <= ds_xor;
			bit_strobe <= ds_edge;
			if (ds_edge)
				got_bit <= 1'b1; // Held until reset
		end
	end

	always_ff @(posedge posedge_clk)
	begin
		bit_value <= din_s; // Data line carries the bit
	end

endmodule

// ==== rtl/char_assembler.sv ====
`timescale 1ns/1ps

module char_assembler (
	input  logic                   posedge_clk,
	input  logic                   rx_resetn,
	input  logic                   bit_strobe,
	input  logic                   bit_value,
	output logic                   char_valid,
	output logic                   char_is_control,
	output spw_rx_pkg::char_word_u char_word
);

	localparam logic [3:0] ctrl_last = 4'(spw_rx_pkg::ctrl_char_bits - 1);
	localparam logic [3:0] data_last = 4'(spw_rx_pkg::data_char_bits - 1);

	logic [3:0]             bit_cnt;    // Position of the next bit
	logic                   ctrl_q;     // Flag of the character in progress
	logic [9:0]             shift_q;
	logic [9:0]             shift_next;
	logic                   ctrl_next;
	logic [3:0]             last_pos;
	logic                   last_bit;
	spw_rx_pkg::char_word_u word_next;

	// --------------------
	// Bit placement and length
	always_comb
	begin
		shift_next          = shift_q;
		shift_next[bit_cnt] = bit_value;

		// Flag is the second bit, length known from then on
		ctrl_next = (bit_cnt == 4'd1) ? bit_value : ctrl_q;
		last_pos  = ctrl_next ? ctrl_last : data_last;
		last_bit  = bit_strobe && (bit_cnt == last_pos);

		word_next = shift_next;
		if (ctrl_next)
			word_next.ctrl.unused = '0; // Stale data bits above the code
	end

	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			bit_cnt    <= '0;
			ctrl_q     <= 1'b0;
			char_valid <= 1'b0;
		end
		else
		begin
			char_valid <= last_bit;
			if (bit_strobe)
			begin
				ctrl_q <= ctrl_next;
				if (last_bit)
					bit_cnt <= '0;
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// --------------------
	// Shift register and character output
	always_ff @(posedge posedge_clk)
	begin
		if (bit_strobe)
			shift_q <= shift_next;

		if (last_bit)
		begin
			char_word       <= word_next;
			char_is_control <= ctrl_next;
		end
	end

endmodule

// ==== rtl/token_detector.sv ====
`timescale 1ns/1ps

module token_detector (
	input  logic                            posedge_clk,
	input  logic                            rx_resetn,
	input  logic                            char_valid,
	input  logic                            char_is_control,
	input  logic                            got_bit,
	input  spw_rx_pkg::char_word_u          char_word,
	output logic                            null_seen,
	output logic                            fct_seen,
	output logic                            nchar_valid,
	output logic                            nchar_eop,
	output logic                            nchar_eep,
	output logic                            time_valid,
	output logic                            got_null,
	output logic                            parity_error,
	output logic [7:0]                      nchar_data,
	output logic [7:0]                      time_code,
	output logic [spw_rx_pkg::info_w-1:0] info
);

	logic       prev_par;    // XOR of the data bits of the last character
	logic       esc_pending;
	logic [3:0] prev_ctrl;
	logic [3:0] cur_ctrl;

	// Last token kind, one-hot
	logic       last_null;
	logic       last_nchar;
	logic       last_time;
	logic       last_fct;

	logic [1:0] code;
	logic [3:0] ctrl_field;
	logic       par_ok;
	logic       data_par;
	logic       is_ctrl;
	logic       is_data;
	logic       tok_null;
	logic       tok_fct;
	logic       tok_nchar;
	logic       tok_time;
	logic       tok_any;

	// --------------------
	// Decode of the incoming character
	always_comb
	begin
		code       = char_word.ctrl.code;
		ctrl_field = {1'b0, char_word.ctrl.flag, code};

		// Parity covers the previous data bits plus this parity and flag
		par_ok   = prev_par ^ char_word.ctrl.parity ^ char_word.ctrl.flag;
		data_par = char_is_control ? ^code : ^char_word.data.value;

		is_ctrl = char_valid && char_is_control;
		is_data = char_valid && !char_is_control;

		tok_null  = is_ctrl && (code == spw_rx_pkg::ctrl_fct) && esc_pending;
		tok_fct   = is_ctrl && (code == spw_rx_pkg::ctrl_fct) && !esc_pending;
		tok_time  = is_data && esc_pending;
		tok_nchar = (is_data && !esc_pending) ||
			(is_ctrl && (code == spw_rx_pkg::ctrl_eop || code == spw_rx_pkg::ctrl_eep));
		tok_any   = tok_null | tok_fct | tok_time | tok_nchar; // ESC alone is no token
	end

	// --------------------
	// Control state and token strobes
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			null_seen    <= 1'b0;
			fct_seen     <= 1'b0;
			nchar_valid  <= 1'b0;
			time_valid   <= 1'b0;
			got_null     <= 1'b0;
			parity_error <= 1'b0;
			prev_par     <= 1'b0;  // No previous character yet
			esc_pending  <= 1'b0;
			prev_ctrl    <= '0;
			cur_ctrl     <= '0;
			last_null    <= 1'b0;
			last_nchar   <= 1'b0;
			last_time    <= 1'b0;
			last_fct     <= 1'b0;
		end
		else
		begin
			null_seen   <= tok_null;
			fct_seen    <= tok_fct;
			nchar_valid <= tok_nchar;
			time_valid  <= tok_time;

			if (char_valid)
			begin
				prev_par    <= data_par;
				esc_pending <= char_is_control && (code == spw_rx_pkg::ctrl_esc);
				if (!par_ok)
					parity_error <= 1'b1; // Sticky
				if (char_is_control)
				begin
					prev_ctrl <= cur_ctrl;
					cur_ctrl  <= ctrl_field;
				end
			end

			if (tok_null)
				got_null <= 1'b1;

			if (tok_any)
			begin
				last_null  <= tok_null;
				last_nchar <= tok_nchar;
				last_time  <= tok_time;
				last_fct   <= tok_fct;
			end
		end
	end

	// Token payload
	always_ff @(posedge posedge_clk)
	begin
		if (tok_nchar)
		begin
			nchar_data <= char_is_control ? 8'h00 : char_word.data.value;
			nchar_eop  <= char_is_control && (code == spw_rx_pkg::ctrl_eop);
			nchar_eep  <= char_is_control && (code == spw_rx_pkg::ctrl_eep);
		end
		if (tok_time)
			time_code <= char_word.data.value;
	end

	// --------------------
	// Status word
	always_comb
	begin
		info = '0;
		info[spw_rx_pkg::info_prev_lsb +: spw_rx_pkg::info_ctrl_w] = prev_ctrl;
		info[spw_rx_pkg::info_cur_lsb +: spw_rx_pkg::info_ctrl_w]  = cur_ctrl;
		info[spw_rx_pkg::info_perr_bit]  = parity_error;
		info[spw_rx_pkg::info_got_bit]   = got_bit;
		info[spw_rx_pkg::info_null_bit]  = last_null;
		info[spw_rx_pkg::info_nchar_bit] = last_nchar;
		info[spw_rx_pkg::info_time_bit]  = last_time;
		info[spw_rx_pkg::info_fct_bit]   = last_fct;
	end

endmodule

// ==== rtl/spw_rx_top.sv ====
`timescale 1ns/1ps

module spw_rx_top #(
	parameter int SYNC_STAGES = 2
) (
	input  logic                            posedge_clk,
	input  logic                            rx_resetn,
	input  logic                            rx_din,
	input  logic                            rx_sin,
	output logic                            got_bit,
	output logic                            null_seen,
	output logic                            fct_seen,
	output logic                            nchar_valid,
	output logic                            nchar_eop,
	output logic                            nchar_eep,
	output logic                            time_valid,
	output logic                            got_null,
	output logic                            parity_error,
	output logic [7:0]                      nchar_data,
	output logic [7:0]                      time_code,
	output logic [spw_rx_pkg::info_w-1:0] info
);

	// --------------------
	// Bit level
	logic bit_strobe;
	logic bit_value;

	ds_bit_sampler #(
		.SYNC_STAGES(SYNC_STAGES)
	) ds_bit_sampler_i (
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.bit_strobe  (bit_strobe),
		.bit_value   (bit_value),
		.got_bit     (got_bit)
	);

	// --------------------
	// Character level
	logic                   char_valid;
	logic                   char_is_control;
	spw_rx_pkg::char_word_u char_word;

	char_assembler char_assembler_i (
		.posedge_clk     (posedge_clk),
		.rx_resetn       (rx_resetn),
		.bit_strobe      (bit_strobe),
		.bit_value       (bit_value),
		.char_valid      (char_valid),
		.char_is_control (char_is_control),
		.char_word       (char_word)
	);

	// Tokens and status
	token_detector token_detector_i (
		.posedge_clk     (posedge_clk),
		.rx_resetn       (rx_resetn),
		.char_valid      (char_valid),
		.char_is_control (char_is_control),
		.got_bit         (got_bit),
		.char_word       (char_word),
		.null_seen       (null_seen),
		.fct_seen        (fct_seen),
		.nchar_valid     (nchar_valid),
		.nchar_eop       (nchar_eop),
		.nchar_eep       (nchar_eep),
		.time_valid      (time_valid),
		.got_null        (got_null),
		.parity_error    (parity_error),
		.nchar_data      (nchar_data),
		.time_code       (time_code),
		.info            (info)
	);

endmodule

// ==== bench/spw_rx_tb.sv ====
`timescale 1ns/1ps

module spw_rx_tb;

	localparam int sync_stages = 2;
	localparam int bit_cycles  = 4;    // Each bit held this long on the line
	localparam int wait_limit  = 200;

	logic                          posedge_clk;
	logic                          rx_resetn;
	logic                          rx_din;
	logic                          rx_sin;
	logic                          got_bit;
	logic                          null_seen;
	logic                          fct_seen;
	logic                          nchar_valid;
	logic                          nchar_eop;
	logic                          nchar_eep;
	logic                          time_valid;
	logic                          got_null;
	logic                          parity_error;
	logic [7:0]                    nchar_data;
	logic [7:0]                    time_code;
	logic [spw_rx_pkg::info_w-1:0] info;

	// --------------------
	// Expected link state
	logic       prev_par;      // XOR of the data bits of the last character sent
	logic [3:0] exp_prev_ctrl;
	logic [3:0] exp_cur_ctrl;
	logic       exp_perr;
	logic       exp_got_null;
	int         char_count;

	spw_rx_top #(
		.SYNC_STAGES(sync_stages)
	) spw_rx_top_i (
		.posedge_clk  (posedge_clk),
		.rx_resetn    (rx_resetn),
		.rx_din       (rx_din),
		.rx_sin       (rx_sin),
		.got_bit      (got_bit),
		.null_seen    (null_seen),
		.fct_seen     (fct_seen),
		.nchar_valid  (nchar_valid),
		.nchar_eop    (nchar_eop),
		.nchar_eep    (nchar_eep),
		.time_valid   (time_valid),
		.got_null     (got_null),
		.parity_error (parity_error),
		.nchar_data   (nchar_data),
		.time_code    (time_code),
		.info         (info)
	);

	initial
	begin
		posedge_clk = 1'b0;
		forever #2 posedge_clk = ~posedge_clk;
	end

	task automatic fail_run();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			$display("Fail %s: got 0x%h expected 0x%h (character %0d)",
				name, got, exp, char_count);
			fail_run();
		end
	endtask

	task automatic check_no_token();
		assert (!(null_seen || fct_seen || nchar_valid || time_valid))
		else
		begin
			$display("A token strobe came while no token was due, character %0d", char_count);
			fail_run();
		end
	endtask

	function automatic logic [1:0] code_of(input logic [7:0] kind);
		case (kind)
			"P":     return spw_rx_pkg::ctrl_eop;
			"E":     return spw_rx_pkg::ctrl_eep;
			"X":     return spw_rx_pkg::ctrl_esc;
			default: return spw_rx_pkg::ctrl_fct;
		endcase
	endfunction

	// --------------------
	// Data-strobe line driver with one D/S transition per bit
	task automatic drive_bit(input logic b);
		if (b == rx_din)
			rx_sin = ~rx_sin;  // Strobe toggles when data holds
		else
			rx_din = b;
		for (int i = 0; i < bit_cycles; i++)
		begin
			@(posedge posedge_clk);
			#1;
			check_no_token();
		end
	endtask

	task automatic send_char(input logic [7:0] kind, input logic [7:0] value, input logic bad);
		logic [9:0] word;
		logic [1:0] code;
		logic       flag;
		logic       parity;
		int         len;
		flag   = (kind != "D");
		code   = code_of(kind);
		parity = ~(prev_par ^ flag);  // prev ^ parity ^ flag must be 1
		if (flag)
		begin
			len           = spw_rx_pkg::ctrl_char_bits;
			word          = {6'b0, code, flag, parity};
			prev_par      = ^code;
			exp_prev_ctrl = exp_cur_ctrl;
			exp_cur_ctrl  = {2'b01, code};
		end
		else
		begin
			len      = spw_rx_pkg::data_char_bits;
			word     = {value, flag, parity};
			prev_par = ^value;
		end
		if (bad)
		begin
			word[0]  = ~word[0];
			exp_perr = 1'b1;
		end
		for (int i = 0; i < len; i++)
		begin
			drive_bit(word[0]);  // Parity first, then flag, then LSB first
			word = word >> 1;
		end
	endtask

	task automatic wait_token();
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < wait_limit)
		begin
			@(posedge posedge_clk);
			#1;
			cycles++;
			seen = null_seen || fct_seen || nchar_valid || time_valid;
		end
		assert (seen)
		else
		begin
			$display("Timeout: no token strobe within %0d cycles of character %0d",
				wait_limit, char_count);
			fail_run();
		end
	endtask

	task automatic check_token(input logic [7:0] value, input logic [7:0] kind,
		input logic [7:0] tok);
		logic [spw_rx_pkg::info_w-1:0] exp_info;
		logic                          exp_null;
		logic                          exp_fct;
		logic                          exp_nchar;
		logic                          exp_time;
		exp_null  = (tok == "n");
		exp_fct   = (tok == "f");
		exp_nchar = (tok == "c");
		exp_time  = (tok == "t");
		if (exp_null)
			exp_got_null = 1'b1;

		check_value("null_seen", 16'(null_seen), 16'(exp_null));
		check_value("fct_seen", 16'(fct_seen), 16'(exp_fct));
		check_value("nchar_valid", 16'(nchar_valid), 16'(exp_nchar));
		check_value("time_valid", 16'(time_valid), 16'(exp_time));
		if (exp_nchar)
		begin
			check_value("nchar_data", 16'(nchar_data), 16'(value));
			check_value("nchar_eop", 16'(nchar_eop), 16'(kind == "P"));
			check_value("nchar_eep", 16'(nchar_eep), 16'(kind == "E"));
		end
		if (exp_time)
			check_value("time_code", 16'(time_code), 16'(value));
		check_value("got_bit", 16'(got_bit), 16'h0001);
		check_value("got_null", 16'(got_null), 16'(exp_got_null));
		check_value("parity_error", 16'(parity_error), 16'(exp_perr));

		exp_info = '0;
		exp_info[spw_rx_pkg::info_prev_lsb +: spw_rx_pkg::info_ctrl_w] = exp_prev_ctrl;
		exp_info[spw_rx_pkg::info_cur_lsb +: spw_rx_pkg::info_ctrl_w]  = exp_cur_ctrl;
		exp_info[spw_rx_pkg::info_perr_bit]  = exp_perr;
		exp_info[spw_rx_pkg::info_got_bit]   = 1'b1;
		exp_info[spw_rx_pkg::info_null_bit]  = exp_null;
		exp_info[spw_rx_pkg::info_nchar_bit] = exp_nchar;
		exp_info[spw_rx_pkg::info_time_bit]  = exp_time;
		exp_info[spw_rx_pkg::info_fct_bit]   = exp_fct;
		check_value("info", 16'(info), 16'(exp_info));
	endtask

	task automatic skip_line(input int fd);
		int c;
		c = $fgetc(fd);
		while (c != 10 && c != -1)
			c = $fgetc(fd);
	endtask

	// --------------------
	// Main sequence
	initial
	begin
		int         fd;
		int         r;
		logic       done;
		logic [7:0] kind;
		logic [7:0] value;
		logic [7:0] bad_flag;
		logic [7:0] tok;
		rx_resetn     = 1'b0;
		rx_din        = 1'b0;
		rx_sin        = 1'b0;
		prev_par      = 1'b0;  // First character has no predecessor
		exp_prev_ctrl = '0;
		exp_cur_ctrl  = '0;
		exp_perr      = 1'b0;
		exp_got_null  = 1'b0;
		char_count    = 0;
		done          = 1'b0;

		repeat (2) @(posedge posedge_clk);
		#1;
		rx_resetn = 1'b1;
		@(posedge posedge_clk);
		#1;
		check_no_token();
		check_value("got_bit", 16'(got_bit), 16'h0000);
		check_value("got_null", 16'(got_null), 16'h0000);
		check_value("parity_error", 16'(parity_error), 16'h0000);
		check_value("info", 16'(info), 16'h0000);

		fd = $fopen("bench/spw_rx_stimulus.txt", "r");
		assert (fd != 0)
		else
		begin
			$display("Could not open the stimulus file bench/spw_rx_stimulus.txt");
			fail_run();
		end

		while (!done)
		begin
			r = $fscanf(fd, "%s", kind);
			if (r != 1)
				done = 1'b1;
			else if (kind == "#")
				skip_line(fd);  // Column description
			else
			begin
				r = $fscanf(fd, "%h %h %s", value, bad_flag, tok);
				char_count++;
				assert (r == 3)
				else
				begin
					$display("Stimulus line for character %0d is incomplete", char_count);
					fail_run();
				end
				send_char(kind, value, bad_flag[0]);
				if (tok != "-")
				begin
					wait_token();
					check_token(value, kind, tok);
				end
			end
		end
		$fclose(fd);

		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== bench/spw_rx_stimulus.txt ====
# kind value bad token
# kind: D data, F fct, P eop, E eep, X esc / token: n null, f fct, c nchar, t time, - none
X 00 0 -
F 00 0 n
X 00 0 -
F 00 0 n
X 00 0 -
F 00 0 n
F 00 0 f
D 41 0 c
D a5 0 c
P 00 0 c
D 3c 0 c
E 00 0 c
X 00 0 -
D 17 0 t
F 00 0 f
D 5a 1 c
D c3 0 c
X 00 0 -
F 00 0 n

// ==== list.f ====
rtl/spw_rx_pkg.sv
rtl/ds_bit_sampler.sv
rtl/char_assembler.sv
rtl/token_detector.sv
rtl/spw_rx_top.sv
bench/spw_rx_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = spw_rx_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
